//--- sim.f
+incdir+src
src/axi_rd_pkg.sv
src/icache_pkg.sv
src/icache_store.sv
src/axi_rd_slice.sv
src/icache_ctrl.sv
src/icache_top.sv
bench/tb_icache.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/icache_patterns.txt
# columns: fetch address, expected data, expected hit, expected AR len (ff = no bus read)
# all hex; memory word = (address >> 2) ^ c0de0000
# cold miss, then the rest of the line hits
00001004 c0de0401 0 03
00001000 c0de0400 1 ff
0000100c c0de0403 1 ff
00001008 c0de0402 1 ff
00002028 c0de080a 0 03
00002020 c0de0808 1 ff
0000202c c0de080b 1 ff
# index 2 shared by two tags
00003020 c0de0c08 0 03
00002024 c0de0809 0 03
00003024 c0de0c09 0 03
00002028 c0de080a 0 03
0000302c c0de0c0b 0 03
00003020 c0de0c08 1 ff
# SRAM window, single beats every time
0f000010 c31e0004 0 00
0f000010 c31e0004 0 00
0f123458 c31a8d16 0 00
00003028 c0de0c0a 1 ff
# just below the window is cached
0efffffc c361ffff 0 03
0efffff0 c361fffc 1 ff
# above the window, evicts line 0
10000000 c4de0000 0 03
10000008 c4de0002 1 ff
0000100c c0de0403 0 03
00001004 c0de0401 1 ff

//--- bench/tb_icache.sv
`timescale 1ns/10ps
`default_nettype none

module tb_icache;
    import icache_pkg::*;
    import axi_rd_pkg::*;

    localparam logic [31:0] MEM_KEY  = 32'hc0de_0000;    // word = word address ^ key
    localparam logic [7:0]  NO_BURST = 8'hff;            // len column of a hit

    logic       clk = 1'b0;
    logic       rst;
    logic       fetch_valid_i;
    logic       fetch_ready_o;
    fetch_req_t fetch_req_i;
    logic       fetch_rvalid_o;
    logic       fetch_rready_i;
    fetch_rsp_t fetch_rsp_o;
    logic       axi_arvalid_o;
    logic       axi_arready_i;
    axi_ar_t    axi_ar_o;
    logic       axi_rvalid_i;
    logic       axi_rready_o;
    axi_r_t     axi_r_i;

    logic [31:0] fetch_rng = 32'd53;    // fetch side back-pressure
    int          cycle_count = 0;
    int          cycle_limit = 100;
    int          ar_total;              // bursts seen on the bus
    axi_ar_t     last_ar;
    axi_ar_t     ar_queue[$];

    logic [31:0] pat_addr[$];
    logic [31:0] pat_data[$];
    logic        pat_hit[$];
    logic [7:0]  pat_len[$];

    icache_top u_icache_top (
        .clk            (clk),
        .rst            (rst),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_ready_o  (fetch_ready_o),
        .fetch_req_i    (fetch_req_i),
        .fetch_rvalid_o (fetch_rvalid_o),
        .fetch_rready_i (fetch_rready_i),
        .fetch_rsp_o    (fetch_rsp_o),
        .axi_arvalid_o  (axi_arvalid_o),
        .axi_arready_i  (axi_arready_i),
        .axi_ar_o       (axi_ar_o),
        .axi_rvalid_i   (axi_rvalid_i),
        .axi_rready_o   (axi_rready_o),
        .axi_r_i        (axi_r_i)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("** Error: no response within %0d cycles, run stopped", cycle_limit);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {2'b00, addr[31:2]} ^ MEM_KEY;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error at %0d ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("** Error at %0d ns: %s", $time, what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) report_mismatch(name, got, exp);
    endtask

    task automatic check_rsp(input fetch_rsp_t got, input fetch_rsp_t exp);
        if (got.data !== exp.data) report_mismatch("fetch_rsp_o.data", got.data, exp.data);
        if (got.hit !== exp.hit) report_mismatch("fetch_rsp_o.hit", 32'(got.hit), 32'(exp.hit));
    endtask

    task automatic check_ar(input axi_ar_t got, input axi_ar_t exp);
        if (got.addr !== exp.addr) report_mismatch("axi_ar_o.addr", got.addr, exp.addr);
        if (got.len !== exp.len) report_mismatch("axi_ar_o.len", 32'(got.len), 32'(exp.len));
        if (got.size !== exp.size) report_mismatch("axi_ar_o.size", 32'(got.size), 32'(exp.size));
        if (got.burst !== exp.burst) begin
            report_mismatch("axi_ar_o.burst", 32'(got.burst), 32'(exp.burst));
        end
    endtask

    // inputs change 1 ns after the edge when outputs have settled
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] hit;
        logic [31:0] len;
        fd = $fopen("bench/icache_patterns.txt", "r");
        if (fd == 0) report_failure("cannot open bench/icache_patterns.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h", addr, data, hit, len);
                if (n != 4) report_failure("malformed line in the pattern file");
                if (mem_word(addr) != data) report_failure("pattern data breaks the memory rule");
                pat_addr.push_back(addr);
                pat_data.push_back(data);
                pat_hit.push_back(hit[0]);
                pat_len.push_back(len[7:0]);
            end
        end
        $fclose(fd);
        if (pat_addr.size() == 0) report_failure("pattern file holds no fetches");
    endtask

    task automatic run_fetch(input int idx);
        fetch_rsp_t  exp_rsp;
        fetch_rsp_t  first_rsp;
        axi_ar_t     exp_ar;
        logic [31:0] addr;
        int          ar_before;
        int          latency;
        logic        done;
        addr         = pat_addr[idx];
        exp_rsp.data = pat_data[idx];
        exp_rsp.hit  = pat_hit[idx];
        ar_before    = ar_total;
        fetch_req_i.addr = addr;
        fetch_valid_i    = 1'b1;
        while (!fetch_ready_o) next_cycle();
        next_cycle();    // request taken at this edge
        fetch_valid_i = 1'b0;
        latency = 0;
        while (!fetch_rvalid_o) begin
            fetch_rng      = xorshift32(fetch_rng);
            fetch_rready_i = fetch_rng[0];
            next_cycle();
            latency = latency + 1;
        end
        if (pat_hit[idx]) check_count("hit latency in cycles", latency, 2);
        first_rsp = fetch_rsp_o;
        check_rsp(first_rsp, exp_rsp);
        // response must stay put while held off at random
        done = 1'b0;
        while (!done) begin
            fetch_rng      = xorshift32(fetch_rng);
            fetch_rready_i = (fetch_rng[1:0] != 2'b00);
            done           = fetch_rready_i;
            next_cycle();
            if (!done) begin
                check_flag("fetch_rvalid_o", fetch_rvalid_o, 1'b1);
                check_rsp(fetch_rsp_o, first_rsp);
            end
        end
        fetch_rready_i = 1'b0;
        check_flag("fetch_rvalid_o", fetch_rvalid_o, 1'b0);
        if (pat_len[idx] == NO_BURST) begin
            check_count("AR bursts per fetch", ar_total - ar_before, 0);
        end else begin
            check_count("AR bursts per fetch", ar_total - ar_before, 1);
            exp_ar.addr  = (pat_len[idx] == 8'd0) ? addr : {addr[31:4], 4'h0};    // 16-byte line
            exp_ar.len   = pat_len[idx];
            exp_ar.size  = 3'd2;    // 4 bytes
            exp_ar.burst = 2'd1;    // INCR
            check_ar(last_ar, exp_ar);
        end
    endtask

    // AXI memory with random AR ready and R valid gaps
    initial begin : bus_responder
        logic [31:0] rng;
        axi_ar_t     burst;
        int          beat;
        logic        taken;
        rng           = xorshift32(32'd53);
        beat          = 0;
        taken         = 1'b0;
        burst         = '0;
        ar_total      = 0;
        last_ar       = '0;
        axi_arready_i = 1'b0;
        axi_rvalid_i  = 1'b0;
        axi_r_i       = '0;
        forever begin
            next_cycle();
            if (taken) begin    // beat went over at this edge
                axi_rvalid_i = 1'b0;
                taken        = 1'b0;
                if (beat == int'(burst.len)) begin
                    burst = ar_queue.pop_front();
                    beat  = 0;
                end else begin
                    beat = beat + 1;
                end
            end
            // R before AR so data never leads its own address handshake
            rng = xorshift32(rng);
            if (!axi_rvalid_i && ar_queue.size() > 0 && rng[1:0] != 2'b00) begin
                burst        = ar_queue[0];
                axi_r_i.data = mem_word(burst.addr + 32'(beat) * 32'd4);
                axi_r_i.last = (beat == int'(burst.len));
                axi_rvalid_i = 1'b1;
            end
            taken = axi_rvalid_i && axi_rready_o;
            rng = xorshift32(rng);
            axi_arready_i = (rng[1:0] != 2'b00);
            if (axi_arvalid_o && axi_arready_i) begin
                last_ar  = axi_ar_o;
                ar_total = ar_total + 1;
                ar_queue.push_back(axi_ar_o);
            end
        end
    end

    initial begin
        rst            = 1'b1;
        fetch_valid_i  = 1'b0;
        fetch_req_i    = '0;
        fetch_rready_i = 1'b0;
        load_patterns();
        cycle_limit = 60 * pat_addr.size() + 100;
        repeat (2) @(posedge clk);
        #1;
        check_flag("fetch_ready_o", fetch_ready_o, 1'b0);
        check_flag("fetch_rvalid_o", fetch_rvalid_o, 1'b0);
        check_flag("axi_arvalid_o", axi_arvalid_o, 1'b0);
        check_flag("axi_rready_o", axi_rready_o, 1'b0);
        rst = 1'b0;
        next_cycle();
        check_flag("fetch_ready_o", fetch_ready_o, 1'b1);    // idle right after reset
        for (int i = 0; i < pat_addr.size(); i++) begin
            run_fetch(i);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_top (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    fetch_valid_i,
    output logic                         fetch_ready_o,
    input  wire icache_pkg::fetch_req_t  fetch_req_i,
    output logic                         fetch_rvalid_o,
    input  wire logic                    fetch_rready_i,
    output icache_pkg::fetch_rsp_t       fetch_rsp_o,
    output logic                         axi_arvalid_o,
    input  wire logic                    axi_arready_i,
    output axi_rd_pkg::axi_ar_t          axi_ar_o,
    input  wire logic                    axi_rvalid_i,
    output logic                         axi_rready_o,
    input  wire axi_rd_pkg::axi_r_t      axi_r_i
);
    import icache_pkg::*;
    import axi_rd_pkg::*;

    // controller side of the slices
    logic      ar_valid;
    logic      ar_ready;
    axi_ar_t   ar;
    logic      r_valid;
    logic      r_ready;
    axi_r_t    r;

    // store access
    index_t    lookup_index;
    logic      line_valid;
    tag_t      line_tag;
    line_t     line_data;
    logic      fill_we;
    index_t    fill_index;
    word_sel_t fill_word;
    logic [31:0] fill_data;
    logic      fill_done;
    tag_t      fill_tag;

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_ready_o  (fetch_ready_o),
        .fetch_req_i    (fetch_req_i),
        .fetch_rvalid_o (fetch_rvalid_o),
        .fetch_rready_i (fetch_rready_i),
        .fetch_rsp_o    (fetch_rsp_o),
        .ar_valid_o     (ar_valid),
        .ar_ready_i     (ar_ready),
        .ar_o           (ar),
        .r_valid_i      (r_valid),
        .r_ready_o      (r_ready),
        .r_i            (r),
        .lookup_index_o (lookup_index),
        .line_valid_i   (line_valid),
        .line_tag_i     (line_tag),
        .line_data_i    (line_data),
        .fill_we_o      (fill_we),
        .fill_index_o   (fill_index),
        .fill_word_o    (fill_word),
        .fill_data_o    (fill_data),
        .fill_done_o    (fill_done),
        .fill_tag_o     (fill_tag)
    );

    icache_store u_store (
        .clk            (clk),
        .rst            (rst),
        .lookup_index_i (lookup_index),
        .line_valid_o   (line_valid),
        .line_tag_o     (line_tag),
        .line_data_o    (line_data),
        .fill_we_i      (fill_we),
        .fill_index_i   (fill_index),
        .fill_word_i    (fill_word),
        .fill_data_i    (fill_data),
        .fill_done_i    (fill_done),
        .fill_tag_i     (fill_tag)
    );

    axi_rd_slice #(.payload_t(axi_ar_t)) u_ar_slice (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (ar_valid),
        .in_ready_o  (ar_ready),
        .in_data_i   (ar),
        .out_valid_o (axi_arvalid_o),
        .out_ready_i (axi_arready_i),
        .out_data_o  (axi_ar_o)
    );

    axi_rd_slice #(.payload_t(axi_r_t)) u_r_slice (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (axi_rvalid_i),
        .in_ready_o  (axi_rready_o),
        .in_data_i   (axi_r_i),
        .out_valid_o (r_valid),
        .out_ready_i (r_ready),
        .out_data_o  (r)
    );

endmodule

`default_nettype wire

//--- src/icache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none
`include "icache_cfg.svh"

module icache_ctrl (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    fetch_valid_i,
    output logic                         fetch_ready_o,
    input  wire icache_pkg::fetch_req_t  fetch_req_i,
    output logic                         fetch_rvalid_o,
    input  wire logic                    fetch_rready_i,
    output icache_pkg::fetch_rsp_t       fetch_rsp_o,
    output logic                         ar_valid_o,
    input  wire logic                    ar_ready_i,
    output axi_rd_pkg::axi_ar_t          ar_o,
    input  wire logic                    r_valid_i,
    output logic                         r_ready_o,
    input  wire axi_rd_pkg::axi_r_t      r_i,
    output icache_pkg::index_t           lookup_index_o,
    input  wire logic                    line_valid_i,
    input  wire icache_pkg::tag_t        line_tag_i,
    input  wire icache_pkg::line_t       line_data_i,
    output logic                         fill_we_o,
    output icache_pkg::index_t           fill_index_o,
    output icache_pkg::word_sel_t        fill_word_o,
    output logic [31:0]                  fill_data_o,
    output logic                         fill_done_o,
    output icache_pkg::tag_t             fill_tag_o
);
    import icache_pkg::*;
    import axi_rd_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_MISS_ADDR,
        S_MISS_DATA,
        S_FILL,
        S_BYP_ADDR,
        S_BYP_DATA,
        S_RESP
    } state_t;

    state_t     state;
    fetch_req_t req_q;
    fetch_rsp_t rsp_q;
    axi_ar_t    ar_q;
    logic       ready_q;
    logic       rvalid_q;
    logic       ar_valid_q;
    logic       r_ready_q;
    word_sel_t  beat_q;        // refill beat, picks the fill word
    tag_t       req_tag;
    index_t     req_index;
    word_sel_t  req_word;
    logic       accept;
    logic       in_window;
    logic       hit;
    logic       r_fire;

    assign req_tag   = req_q.addr[31 -: TAG_W];
    assign req_index = req_q.addr[OFFSET_W +: INDEX_W];
    assign req_word  = req_q.addr[2 +: WORD_W];

    assign accept    = (state == S_IDLE) && fetch_valid_i && ready_q;
    assign in_window = (fetch_req_i.addr >= `SRAM_BASE) &&
                       (fetch_req_i.addr < (`SRAM_BASE + `SRAM_SIZE));
    assign hit       = line_valid_i && (line_tag_i == req_tag);
    assign r_fire    = r_valid_i && r_ready_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            ready_q    <= 1'b0;
            rvalid_q   <= 1'b0;
            ar_valid_q <= 1'b0;
            r_ready_q  <= 1'b0;
            beat_q     <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        ready_q <= 1'b0;
                        if (in_window) begin
                            ar_valid_q <= 1'b1;    // uncached, straight to the bus
                            state      <= S_BYP_ADDR;
                        end else begin
                            state <= S_LOOKUP;
                        end
                    end else begin
                        ready_q <= 1'b1;
                    end
                end
                S_LOOKUP: begin
                    if (hit) begin
                        state <= S_RESP;
                    end else begin
                        ar_valid_q <= 1'b1;
                        state      <= S_MISS_ADDR;
                    end
                end
                S_MISS_ADDR: begin
                    if (ar_ready_i) begin
                        ar_valid_q <= 1'b0;
                        r_ready_q  <= 1'b1;
                        beat_q     <= '0;
                        state      <= S_MISS_DATA;
                    end
                end
                S_MISS_DATA: begin
                    if (r_fire) begin
                        beat_q <= beat_q + 1'b1;
                        if (r_i.last) begin
                            r_ready_q <= 1'b0;
                            state     <= S_FILL;
                        end
                    end
                end
                S_FILL: state <= S_RESP;    // read back the finished line
                S_BYP_ADDR: begin
                    if (ar_ready_i) begin
                        ar_valid_q <= 1'b0;
                        r_ready_q  <= 1'b1;
                        state      <= S_BYP_DATA;
                    end
                end
                S_BYP_DATA: begin
                    if (r_fire) begin
                        r_ready_q <= 1'b0;
                        state     <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (!rvalid_q) begin
                        rvalid_q <= 1'b1;
                    end else if (fetch_rready_i) begin
                        rvalid_q <= 1'b0;
                        ready_q  <= 1'b1;
                        state    <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // request, response and AR payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q      <= fetch_req_i;
            ar_q.addr  <= fetch_req_i.addr;    // bypass uses the exact address
            ar_q.len   <= 8'd0;
            ar_q.size  <= AXI_SIZE_WORD;
            ar_q.burst <= AXI_BURST_INCR;
        end
        if (state == S_LOOKUP) begin
            rsp_q.data <= line_data_i[req_word*32 +: 32];
            rsp_q.hit  <= hit;
            ar_q.addr  <= {req_q.addr[31:OFFSET_W], {OFFSET_W{1'b0}}};    // line aligned
            ar_q.len   <= 8'(`ICACHE_LINE_BYTES / 4 - 1);
        end
        if (state == S_FILL) begin
            rsp_q.data <= line_data_i[req_word*32 +: 32];
            rsp_q.hit  <= 1'b0;
        end
        if (state == S_BYP_DATA && r_fire) begin
            rsp_q.data <= r_i.data;
            rsp_q.hit  <= 1'b0;
        end
    end

    assign fetch_ready_o  = ready_q;
    assign fetch_rvalid_o = rvalid_q;
    assign fetch_rsp_o    = rsp_q;
    assign ar_valid_o     = ar_valid_q;
    assign ar_o           = ar_q;
    assign r_ready_o      = r_ready_q;
    assign lookup_index_o = req_index;

    // fill path straight from the R beat
    assign fill_we_o    = (state == S_MISS_DATA) && r_fire;
    assign fill_index_o = req_index;
    assign fill_word_o  = beat_q;
    assign fill_data_o  = r_i.data;
    assign fill_done_o  = fill_we_o && r_i.last;
    assign fill_tag_o   = req_tag;

    assert property (@(posedge clk) disable iff (rst)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));

    // refill burst ends exactly on its fourth beat
    assert property (@(posedge clk) disable iff (rst)
        fill_we_o |-> (r_i.last == (&beat_q)));

endmodule

`default_nettype wire

//--- src/axi_rd_slice.sv
`timescale 1ns/10ps
`default_nettype none

module axi_rd_slice #(
    parameter type payload_t = logic [31:0]
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       in_valid_i,
    output logic            in_ready_o,
    input  wire payload_t   in_data_i,
    output logic            out_valid_o,
    input  wire logic       out_ready_i,
    output payload_t        out_data_o
);

    logic     out_valid_q;
    logic     skid_valid_q;
    logic     in_ready_q;
    payload_t out_data_q;
    payload_t skid_data_q;
    logic     out_free;
    logic     accept;

    assign out_free = !out_valid_q || out_ready_i;    // output register can load
    assign accept   = in_valid_i && in_ready_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
            in_ready_q   <= 1'b0;
        end else if (out_free) begin
            // skid drains first, input is blocked while it is full
            out_valid_q  <= skid_valid_q || accept;
            skid_valid_q <= 1'b0;
            in_ready_q   <= 1'b1;
        end else if (accept) begin
            skid_valid_q <= 1'b1;    // output stalled, park the item
            in_ready_q   <= 1'b0;
        end else begin
            in_ready_q   <= !skid_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data_q <= skid_valid_q ? skid_data_q : in_data_i;
        end
        if (accept && !out_free) begin
            skid_data_q <= in_data_i;
        end
    end

    assign in_ready_o  = in_ready_q;
    assign out_valid_o = out_valid_q;
    assign out_data_o  = out_data_q;

    assert property (@(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

`default_nettype wire

//--- src/icache_store.sv
`timescale 1ns/10ps
`default_nettype none
`include "icache_cfg.svh"

module icache_store (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire icache_pkg::index_t     lookup_index_i,
    output logic                        line_valid_o,
    output icache_pkg::tag_t            line_tag_o,
    output icache_pkg::line_t           line_data_o,
    input  wire logic                   fill_we_i,
    input  wire icache_pkg::index_t     fill_index_i,
    input  wire icache_pkg::word_sel_t  fill_word_i,
    input  wire logic [31:0]            fill_data_i,
    input  wire logic                   fill_done_i,
    input  wire icache_pkg::tag_t       fill_tag_i
);
    import icache_pkg::*;

    logic [`ICACHE_LINES-1:0] valid_q;
    tag_t                     tag_mem  [`ICACHE_LINES];
    line_t                    data_mem [`ICACHE_LINES];
    index_t                   last_fill_index_q;

    // combinational read at the lookup index
    assign line_valid_o = valid_q[lookup_index_i];
    assign line_tag_o   = tag_mem[lookup_index_i];
    assign line_data_o  = data_mem[lookup_index_i];

    // a line being refilled is not valid until its last word lands
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_done_i) begin
            valid_q[fill_index_i] <= 1'b1;
        end else if (fill_we_i) begin
            valid_q[fill_index_i] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we_i) begin
            data_mem[fill_index_i][fill_word_i*32 +: 32] <= fill_data_i;
            last_fill_index_q <= fill_index_i;
        end
        if (fill_done_i) begin
            tag_mem[fill_index_i] <= fill_tag_i;    // tag written with last word
        end
    end

    // done closes a refill of the same line, together with its final word
    assert property (@(posedge clk) disable iff (rst)
        fill_done_i |-> fill_we_i && (fill_index_i == last_fill_index_q));

endmodule

`default_nettype wire

//--- src/icache_pkg.sv
`default_nettype none
`include "icache_cfg.svh"

package icache_pkg;

    // fetch address split:  tag | index | word | byte
    localparam int OFFSET_W = $clog2(`ICACHE_LINE_BYTES);
    localparam int INDEX_W  = $clog2(`ICACHE_LINES);
    localparam int WORD_W   = $clog2(`ICACHE_LINE_BYTES / 4);
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;

    typedef logic [TAG_W-1:0]                 tag_t;
    typedef logic [INDEX_W-1:0]               index_t;
    typedef logic [WORD_W-1:0]                word_sel_t;
    typedef logic [`ICACHE_LINE_BYTES*8-1:0]  line_t;     // word 0 in low bits

    typedef struct packed {
        logic [31:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        hit;       // served from a valid matching line
    } fetch_rsp_t;

endpackage

`default_nettype wire

//--- src/axi_rd_pkg.sv
`default_nettype none

package axi_rd_pkg;

    // burst and size codes
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;    // 4 bytes per beat

    // read address channel
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;       // beats minus one
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    // read data channel
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } axi_r_t;

endpackage

`default_nettype wire

//--- src/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// cache geometry
`define ICACHE_LINES      16
`define ICACHE_LINE_BYTES 16

// uncached SRAM window, fetched one word at a time
`define SRAM_BASE         32'h0f00_0000
`define SRAM_SIZE         32'h00ff_ffff

`endif
